// ==== source/afu_pkg.sv ====
package afu_pkg;

	// ------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------
	localparam int line_w          = 512;
	localparam int addr_w          = 58;
	localparam int lane_w          = 128;
	localparam int num_lanes       = 4;
	localparam int fifo_depth_log2 = 2;

	// ------------------------------------------------------------------
	// handshake line layout
	// ------------------------------------------------------------------
	// ready tags alternate between batches
	localparam int tag0_bit  = 480;
	localparam int tag1_bit  = 482;
	localparam int batch_lsb = 448;
	localparam int batch_w   = 7;

	// cache lines per read in the input area
	localparam int lines_per_read = 4;

	// fence is flagged in the top data bit of a write
	localparam int fence_bit = 511;
	// completion value, lands in bits 511:480
	localparam int done_code = 16;

	typedef logic [line_w-1:0]  line_t;
	typedef logic [addr_w-1:0]  addr_t;
	typedef logic [lane_w-1:0]  lane_t;
	typedef logic [batch_w-1:0] batch_t;

	// one host write
	typedef struct packed {
		addr_t addr;
		line_t data;
	} wr_req_t;

	typedef enum logic [3:0] {
		idle,
		poll_issue,
		poll_wait,
		load_reads,
		run,
		drain_output,
		fence_1,
		done_write,
		fence_2
	} seq_state_t;

endpackage

// ==== source/rsp_lanes_if.sv ====
`timescale 1ns/10ps

interface rsp_lanes_if
	import afu_pkg::*;
();
	// write side, one enable per lane
	logic  [num_lanes-1:0]        k_wr_en;
	logic  [num_lanes-1:0]        l_wr_en;
	lane_t [num_lanes-1:0]        k_wr_data;
	lane_t [num_lanes-1:0]        l_wr_data;

	// read side
	logic  [num_lanes-1:0]        k_empty;
	logic  [num_lanes-1:0]        l_empty;
	lane_t [num_lanes-1:0]        k_rd_data;
	lane_t [num_lanes-1:0]        l_rd_data;
	logic  [num_lanes-1:0]        k_valid;
	logic  [num_lanes-1:0]        l_valid;
	// shared by all eight lanes
	logic                         pop;

	modport steer (
		output k_wr_en, l_wr_en, k_wr_data, l_wr_data
	);

	// pair side of the lanes
	modport joiner (
		input  k_empty, l_empty, k_rd_data, l_rd_data, k_valid, l_valid,
		output pop
	);

endinterface

// ==== source/lane_fifo.sv ====
`timescale 1ns/10ps

module lane_fifo
	import afu_pkg::*;
#(
	parameter type payload_t = lane_t
) (
	input  logic     CLK_200M,
	input  logic     reset_n,
	input  logic     clear,
	input  logic     wr_en,
	input  payload_t wr_data,
	input  logic     rd_en,
	output payload_t rd_data,
	output logic     data_valid,
	output logic     empty,
	output logic     full
);
	payload_t                 mem [2**fifo_depth_log2];
	// one extra bit tells full from empty
	logic [fifo_depth_log2:0] wr_ptr;
	logic [fifo_depth_log2:0] rd_ptr;
	logic                     do_write;
	logic                     do_read;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[fifo_depth_log2] != rd_ptr[fifo_depth_log2]) &&
		(wr_ptr[fifo_depth_log2-1:0] == rd_ptr[fifo_depth_log2-1:0]);

	assign do_write = wr_en && !full;
	assign do_read  = rd_en && !empty;

	always_ff @(posedge CLK_200M) begin
		if (!reset_n || clear) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			data_valid <= 1'b0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			data_valid <= do_read;
		end
	end

	// storage and registered head
	always_ff @(posedge CLK_200M) begin
		if (do_write)
			mem[wr_ptr[fifo_depth_log2-1:0]] <= wr_data;
		if (do_read)
			rd_data <= mem[rd_ptr[fifo_depth_log2-1:0]];
	end

	a_no_overflow: assert property (@(posedge CLK_200M) disable iff (!reset_n || clear)
		!(wr_en && full));

	a_no_underflow: assert property (@(posedge CLK_200M) disable iff (!reset_n || clear)
		!(rd_en && empty));

endmodule

// ==== source/response_steer.sv ====
`timescale 1ns/10ps

module response_steer
	import afu_pkg::*;
(
	input  logic              CLK_200M,
	input  logic              reset_n,
	input  logic              rx_rd_valid,
	input  line_t             rx_rd_data,
	rsp_lanes_if.steer        lanes
);
	// low for k, high for l
	logic  odd_tag;
	line_t line_q;

	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			odd_tag       <= 1'b0;
			lanes.k_wr_en <= '0;
			lanes.l_wr_en <= '0;
		end else begin
			lanes.k_wr_en <= {num_lanes{rx_rd_valid && !odd_tag}};
			lanes.l_wr_en <= {num_lanes{rx_rd_valid && odd_tag}};
			if (rx_rd_valid)
				odd_tag <= !odd_tag;
		end
	end

	always_ff @(posedge CLK_200M) begin
		line_q <= rx_rd_data;
	end

	// both sides see the same slices, the enables pick the side
	assign lanes.k_wr_data = line_q;
	assign lanes.l_wr_data = line_q;

	a_one_side: assert property (@(posedge CLK_200M) disable iff (!reset_n)
		!(|lanes.k_wr_en && |lanes.l_wr_en));

endmodule

// ==== source/pair_join.sv ====
`timescale 1ns/10ps

module pair_join
	import afu_pkg::*;
(
	input  logic              CLK_200M,
	input  logic              reset_n,
	rsp_lanes_if.joiner       lanes,
	output logic              pair_valid,
	output line_t             pair_k,
	output line_t             pair_l
);

	// ------------------------------------------------------------------
	// pop only when every k and l lane holds data
	// ------------------------------------------------------------------
	// one common pop keeps the eight lanes in step
	assign lanes.pop = ~|{lanes.k_empty, lanes.l_empty};

	// lane 0 speaks for the rest
	assign pair_valid = lanes.k_valid[0];

	// lane i maps to bits i*lane_w upward
	assign pair_k = lanes.k_rd_data;
	assign pair_l = lanes.l_rd_data;

	a_lanes_aligned: assert property (@(posedge CLK_200M) disable iff (!reset_n)
		(lanes.k_valid == {num_lanes{lanes.k_valid[0]}}) &&
		(lanes.l_valid == {num_lanes{lanes.k_valid[0]}}));

endmodule

// ==== source/job_sequencer.sv ====
`timescale 1ns/10ps

module job_sequencer
	import afu_pkg::*;
(
	input  logic        CLK_200M,
	input  logic        reset_n,
	input  logic        core_start,
	input  logic        rd_almostfull,
	input  logic        wr_almostfull,
	input  addr_t       hand_ptr,
	input  addr_t       src_ptr,
	input  addr_t       dst_ptr,
	input  addr_t       input_base,
	input  logic        pair_valid,
	input  line_t       pair_k,
	input  line_t       pair_l,
	output logic        req_push,
	output addr_t       req_addr,
	output logic        wr_push,
	output wr_req_t     wr_req,
	output logic        eng_reset_n,
	output logic        eng_load_valid,
	output line_t       eng_load_data,
	input  logic        eng_load_done,
	output batch_t      eng_batch_size,
	input  logic        eng_req_valid,
	input  logic [31:0] eng_addr_k,
	input  logic [31:0] eng_addr_l,
	input  logic        eng_req_done,
	output logic        eng_rsp_valid,
	output line_t       eng_rsp_k,
	output line_t       eng_rsp_l,
	output logic        eng_out_permit,
	input  logic        eng_out_valid,
	input  line_t       eng_out_data,
	input  logic        eng_out_finish
);
	seq_state_t         state;
	logic               stall;
	logic               polling_tag;
	// second push of a k/l pair
	logic               phase;
	logic [batch_w+1:0] load_ptr;
	logic [batch_w+1:0] load_lines;
	logic [1:0]         lookup_cnt;
	addr_t              lookup_k;
	addr_t              lookup_l;
	logic               out_pend;
	line_t              out_data;
	addr_t              out_idx;
	logic               done_seen;
	logic               poll_hit;

	assign load_lines = (batch_w+2)'(eng_batch_size) * (batch_w+2)'(lines_per_read);
	assign poll_hit   = polling_tag ? pair_l[tag1_bit] : pair_l[tag0_bit];

	always_ff @(posedge CLK_200M) begin
		if (!reset_n)
			stall <= 1'b0;
		else
			stall <= rd_almostfull | wr_almostfull;
	end

	// response lines to the engine
	always_ff @(posedge CLK_200M) begin
		eng_load_data <= pair_k;
		eng_rsp_k     <= pair_k;
		eng_rsp_l     <= pair_l;
	end

	// ------------------------------------------------------------------
	// batch FSM
	// ------------------------------------------------------------------
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			state          <= idle;
			polling_tag    <= 1'b0;
			phase          <= 1'b0;
			load_ptr       <= '0;
			lookup_cnt     <= '0;
			out_pend       <= 1'b0;
			out_idx        <= '0;
			done_seen      <= 1'b0;
			req_push       <= 1'b0;
			wr_push        <= 1'b0;
			eng_reset_n    <= 1'b0;
			eng_load_valid <= 1'b0;
			eng_rsp_valid  <= 1'b0;
			eng_out_permit <= 1'b0;
		end else begin
			req_push       <= 1'b0;
			wr_push        <= 1'b0;
			eng_load_valid <= (state == load_reads) && pair_valid;
			eng_rsp_valid  <= (state == run) && pair_valid;
			case (state)
			idle: begin
				// polling tag carries over to the next batch
				eng_reset_n    <= 1'b0;
				phase          <= 1'b0;
				load_ptr       <= '0;
				lookup_cnt     <= '0;
				out_pend       <= 1'b0;
				out_idx        <= '0;
				done_seen      <= 1'b0;
				eng_out_permit <= 1'b0;
				if (core_start)
					state <= poll_issue;
			end
			poll_issue: begin
				eng_reset_n <= 1'b1;
				if (!stall) begin
					req_push <= 1'b1;
					req_addr <= hand_ptr;
					phase    <= !phase;
					if (phase)
						state <= poll_wait;
				end
			end
			poll_wait: begin
				// tag sits in the l line of the pair
				if (pair_valid) begin
					if (poll_hit) begin
						eng_batch_size <= pair_l[batch_lsb +: batch_w];
						polling_tag    <= !polling_tag;
						state          <= load_reads;
					end else begin
						state <= poll_issue;
					end
				end
			end
			load_reads: begin
				if (!stall && load_ptr < load_lines) begin
					req_push <= 1'b1;
					req_addr <= input_base + addr_t'(load_ptr);
					phase    <= !phase;
					if (phase)
						load_ptr <= load_ptr + 1'b1;
				end
				if (eng_load_done)
					state <= run;
			end
			run: begin
				if (!stall && lookup_cnt != 2'd0) begin
					req_push   <= 1'b1;
					req_addr   <= (lookup_cnt == 2'd2) ? lookup_k : lookup_l;
					lookup_cnt <= lookup_cnt - 1'b1;
				end
				// one lookup held at a time, engine spaces its requests
				if (eng_req_valid) begin
					lookup_k   <= src_ptr + addr_t'(eng_addr_k[31:4]);
					lookup_l   <= src_ptr + addr_t'(eng_addr_l[31:4]);
					lookup_cnt <= 2'd2;
				end
				if (eng_req_done)
					done_seen <= 1'b1;
				if ((done_seen || eng_req_done) && lookup_cnt == 2'd0 && !eng_req_valid) begin
					done_seen      <= 1'b0;
					eng_out_permit <= 1'b1;
					state          <= drain_output;
				end
			end
			drain_output: begin
				if (out_pend && !stall) begin
					wr_push     <= 1'b1;
					wr_req.addr <= dst_ptr + out_idx;
					wr_req.data <= out_data;
					out_idx     <= out_idx + 1'b1;
					out_pend    <= 1'b0;
				end
				if (eng_out_valid) begin
					out_pend <= 1'b1;
					out_data <= eng_out_data;
				end
				if (eng_out_finish)
					done_seen <= 1'b1;
				if ((done_seen || eng_out_finish) && !out_pend && !eng_out_valid) begin
					done_seen <= 1'b0;
					state     <= fence_1;
				end
			end
			fence_1: begin
				if (!stall) begin
					wr_push <= 1'b1;
					wr_req  <= '{addr: '0, data: line_t'(1'b1) << fence_bit};
					state   <= done_write;
				end
			end
			done_write: begin
				if (!stall) begin
					wr_push <= 1'b1;
					wr_req  <= '{addr: hand_ptr,
						data: {32'(done_code), {(line_w-32){1'b0}}}};
					state   <= fence_2;
				end
			end
			fence_2: begin
				if (!stall) begin
					wr_push <= 1'b1;
					wr_req  <= '{addr: '0, data: line_t'(1'b1) << fence_bit};
					state   <= idle;
				end
			end
			default: state <= idle;
			endcase
		end
	end

	// push decided from the stall seen one cycle earlier
	a_no_push_in_stall: assert property (@(posedge CLK_200M) disable iff (!reset_n)
		stall |=> !(req_push || wr_push));

endmodule

// ==== source/afu_core.sv ====
`timescale 1ns/10ps

module afu_core
	import afu_pkg::*;
(
	input  logic        CLK_200M,
	input  logic        reset_n,
	input  logic        core_start,
	input  logic        rd_almostfull,
	input  logic        wr_almostfull,
	output logic        tx_rd_valid,
	output addr_t       tx_rd_addr,
	output logic        tx_wr_valid,
	output addr_t       tx_wr_addr,
	output line_t       tx_wr_data,
	output logic        tx_fence_valid,
	input  logic        rx_rd_valid,
	input  line_t       rx_rd_data,
	input  addr_t       hand_ptr,
	input  addr_t       src_ptr,
	input  addr_t       dst_ptr,
	input  addr_t       input_base,
	output logic        eng_reset_n,
	output logic        eng_load_valid,
	output line_t       eng_load_data,
	input  logic        eng_load_done,
	output batch_t      eng_batch_size,
	input  logic        eng_req_valid,
	input  logic [31:0] eng_addr_k,
	input  logic [31:0] eng_addr_l,
	input  logic        eng_req_done,
	output logic        eng_rsp_valid,
	output line_t       eng_rsp_k,
	output line_t       eng_rsp_l,
	output logic        eng_out_permit,
	input  logic        eng_out_valid,
	input  line_t       eng_out_data,
	input  logic        eng_out_finish
);
	rsp_lanes_if lanes ();

	logic    fifo_clear;
	logic    pair_valid;
	line_t   pair_k;
	line_t   pair_l;
	logic    req_push;
	addr_t   req_addr;
	logic    req_empty;
	logic    req_valid;
	addr_t   req_head;
	logic    wr_push;
	wr_req_t wr_req;
	logic    wr_empty;
	logic    wr_valid;
	wr_req_t wr_head;

	// queues only hold data while the core is started
	assign fifo_clear = !core_start;

	job_sequencer u_seq (
		.CLK_200M, .reset_n, .core_start, .rd_almostfull, .wr_almostfull,
		.hand_ptr, .src_ptr, .dst_ptr, .input_base,
		.pair_valid, .pair_k, .pair_l,
		.req_push, .req_addr, .wr_push, .wr_req,
		.eng_reset_n, .eng_load_valid, .eng_load_data, .eng_load_done, .eng_batch_size,
		.eng_req_valid, .eng_addr_k, .eng_addr_l, .eng_req_done,
		.eng_rsp_valid, .eng_rsp_k, .eng_rsp_l,
		.eng_out_permit, .eng_out_valid, .eng_out_data, .eng_out_finish
	);

	// ------------------------------------------------------------------
	// response path
	// ------------------------------------------------------------------
	response_steer u_steer (
		.CLK_200M, .reset_n, .rx_rd_valid, .rx_rd_data, .lanes(lanes.steer)
	);

	for (genvar i = 0; i < num_lanes; i++) begin : g_lane
		lane_fifo #(.payload_t(lane_t)) u_k (
			.CLK_200M, .reset_n, .clear(fifo_clear),
			.wr_en(lanes.k_wr_en[i]), .wr_data(lanes.k_wr_data[i]),
			.rd_en(lanes.pop), .rd_data(lanes.k_rd_data[i]),
			.data_valid(lanes.k_valid[i]), .empty(lanes.k_empty[i]), .full()
		);
		lane_fifo #(.payload_t(lane_t)) u_l (
			.CLK_200M, .reset_n, .clear(fifo_clear),
			.wr_en(lanes.l_wr_en[i]), .wr_data(lanes.l_wr_data[i]),
			.rd_en(lanes.pop), .rd_data(lanes.l_rd_data[i]),
			.data_valid(lanes.l_valid[i]), .empty(lanes.l_empty[i]), .full()
		);
	end

	pair_join u_join (
		.CLK_200M, .reset_n, .lanes(lanes.joiner), .pair_valid, .pair_k, .pair_l
	);

	// ------------------------------------------------------------------
	// request and write queues, drained every cycle
	// ------------------------------------------------------------------
	lane_fifo #(.payload_t(addr_t)) u_req_queue (
		.CLK_200M, .reset_n, .clear(fifo_clear),
		.wr_en(req_push), .wr_data(req_addr),
		.rd_en(!req_empty), .rd_data(req_head),
		.data_valid(req_valid), .empty(req_empty), .full()
	);

	lane_fifo #(.payload_t(wr_req_t)) u_wr_queue (
		.CLK_200M, .reset_n, .clear(fifo_clear),
		.wr_en(wr_push), .wr_data(wr_req),
		.rd_en(!wr_empty), .rd_data(wr_head),
		.data_valid(wr_valid), .empty(wr_empty), .full()
	);

	// tx strobes
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			tx_rd_valid    <= 1'b0;
			tx_wr_valid    <= 1'b0;
			tx_fence_valid <= 1'b0;
		end else begin
			tx_rd_valid    <= req_valid;
			tx_wr_valid    <= wr_valid;
			tx_fence_valid <= wr_valid && wr_head.data[fence_bit];
		end
	end

	always_ff @(posedge CLK_200M) begin
		tx_rd_addr <= req_head;
		tx_wr_addr <= wr_head.addr;
		tx_wr_data <= wr_head.data;
	end

endmodule

// ==== bench/tb_checks.svh ====
// ----------------------------------------------------------------------
// counters and expected streams
// ----------------------------------------------------------------------
int      checks;
int      errors;
addr_t   exp_rd[$];
wr_req_t exp_wr[$];
bit      exp_fence[$];

task automatic report_error(input string what);
	errors++;
	$display("ERROR at %0t: %s", $time, what);
endtask

task automatic check_addr(input string name, input addr_t got, input addr_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_line(input string name, input line_t got, input line_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_wr(input string name, input wr_req_t got, input wr_req_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAILED at %0t: %s got %h/%h expected %h/%h", $time, name,
			got.addr, got.data, exp.addr, exp.data);
	end
endtask

task automatic check_batch(input string name, input batch_t got, input batch_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
	end
endtask

// reads and writes of one batch of n, in host order
function automatic void build_expected(input int n);
	line_t fence;
	fence = '0;
	fence[fence_bit] = 1'b1;
	for (int i = 0; i < n * lines_per_read; i++) begin
		exp_rd.push_back(input_base + addr_t'(i));
		exp_rd.push_back(input_base + addr_t'(i));
	end
	foreach (lk_k[j]) begin
		exp_rd.push_back(src_ptr + addr_t'(lk_k[j][31:4]));
		exp_rd.push_back(src_ptr + addr_t'(lk_l[j][31:4]));
	end
	// only the two closing fences raise the fence strobe
	foreach (res[j]) begin
		exp_wr.push_back('{addr: dst_ptr + addr_t'(j), data: res[j]});
		exp_fence.push_back(1'b0);
	end
	exp_wr.push_back('{addr: '0, data: fence});
	exp_fence.push_back(1'b1);
	exp_wr.push_back('{addr: hand_ptr, data: {32'(done_code), {(line_w-32){1'b0}}}});
	exp_fence.push_back(1'b0);
	exp_wr.push_back('{addr: '0, data: fence});
	exp_fence.push_back(1'b1);
endfunction

// ==== bench/tb_afu_core.sv ====
`timescale 1ns/10ps

module tb_afu_core
	import afu_pkg::*;
();
	logic        CLK_200M;
	logic        reset_n;
	logic        core_start;
	logic        rd_almostfull;
	logic        wr_almostfull;
	logic        tx_rd_valid;
	addr_t       tx_rd_addr;
	logic        tx_wr_valid;
	addr_t       tx_wr_addr;
	line_t       tx_wr_data;
	logic        tx_fence_valid;
	logic        rx_rd_valid;
	line_t       rx_rd_data;
	addr_t       hand_ptr;
	addr_t       src_ptr;
	addr_t       dst_ptr;
	addr_t       input_base;
	logic        eng_reset_n;
	logic        eng_load_valid;
	line_t       eng_load_data;
	logic        eng_load_done;
	batch_t      eng_batch_size;
	logic        eng_req_valid;
	logic [31:0] eng_addr_k;
	logic [31:0] eng_addr_l;
	logic        eng_req_done;
	logic        eng_rsp_valid;
	line_t       eng_rsp_k;
	line_t       eng_rsp_l;
	logic        eng_out_permit;
	logic        eng_out_valid;
	line_t       eng_out_data;
	logic        eng_out_finish;

	logic [31:0] lk_k[$];
	logic [31:0] lk_l[$];
	line_t       res[$];
	line_t       mem[addr_t];
	addr_t       rq_addr[$];
	int          rq_due[$];
	int          poll_reads;
	int          wr_seen;
	int          cyc;
	bit          in_batch;
	bit          stall_en;

	`include "tb_checks.svh"

	afu_core dut (.*);

	// untouched lines carry their own address
	function automatic line_t fill_line(input addr_t a);
		return {8{a, 6'h2b}};
	endfunction

	function automatic line_t mem_read(input addr_t a);
		return mem.exists(a) ? mem[a] : fill_line(a);
	endfunction

	task automatic timeout_fail(input string what);
		$display("timeout while waiting for %s at %0t", what, $time);
		$display("** FAIL **");
		$finish;
	endtask

	task automatic report_test(input int num, input string name, input int err0);
		$display("test %0d %s: %s", num, name, (errors == err0) ? "passed" : "failed");
	endtask

	initial begin
		CLK_200M = 1'b0;
		forever #5 CLK_200M = ~CLK_200M;
	end

	// ------------------------------------------------------------------
	// host model, answers in request order after a random delay
	// ------------------------------------------------------------------
	initial forever begin
		int due;
		@(posedge CLK_200M);
		cyc++;
		rx_rd_valid <= 1'b0;
		if (tx_rd_valid) begin
			due = cyc + 2 + int'($urandom_range(0, 5));
			if (rq_due.size() > 0 && due <= rq_due[$])
				due = rq_due[$] + 1;
			rq_addr.push_back(tx_rd_addr);
			rq_due.push_back(due);
		end
		if (rq_due.size() > 0 && rq_due[0] <= cyc) begin
			rx_rd_valid <= 1'b1;
			rx_rd_data  <= mem_read(rq_addr.pop_front());
			void'(rq_due.pop_front());
		end
		if (tx_wr_valid && !tx_fence_valid)
			mem[tx_wr_addr] = tx_wr_data;
		rd_almostfull <= stall_en && ($urandom_range(0, 3) == 0);
		wr_almostfull <= stall_en && ($urandom_range(0, 3) == 0);
	end

	// compare every tx strobe with the expected streams
	initial forever begin
		wr_req_t e;
		@(posedge CLK_200M);
		if (tx_rd_valid) begin
			if (!in_batch && tx_rd_addr == hand_ptr) begin
				poll_reads++;
			end else if (exp_rd.size() == 0) begin
				report_error("read issued while none was expected");
			end else begin
				if (!in_batch && poll_reads % 2 != 0)
					report_error("handshake reads did not come in pairs");
				in_batch = 1'b1;
				check_addr("tx_rd_addr", tx_rd_addr, exp_rd.pop_front());
			end
		end
		if (tx_wr_valid) begin
			if (exp_wr.size() == 0) begin
				report_error("write issued while none was expected");
			end else begin
				e = exp_wr.pop_front();
				check_wr("tx_wr", '{addr: tx_wr_addr, data: tx_wr_data}, e);
				check_bit("tx_fence_valid", tx_fence_valid, exp_fence.pop_front());
				wr_seen++;
				if (exp_wr.size() == 0 && exp_rd.size() == 0)
					in_batch = 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------
	// engine side of one batch
	// ------------------------------------------------------------------
	task automatic poll_phase(input int n, input bit tag);
		line_t h;
		int    p0;
		int    t;
		h = '0;
		h[tag ? tag0_bit : tag1_bit] = 1'b1;
		mem[hand_ptr] = h;
		build_expected(n);
		p0 = poll_reads;
		for (t = 0; t < 2000 && poll_reads < p0 + 6; t++)
			@(posedge CLK_200M);
		if (poll_reads < p0 + 6)
			timeout_fail("handshake polling");
		if (in_batch)
			report_error("loading started before the ready tag was set");
		h = '0;
		h[tag ? tag1_bit : tag0_bit] = 1'b1;
		h[batch_lsb +: batch_w] = batch_t'(n);
		mem[hand_ptr] = h;
		for (t = 0; t < 2000 && !in_batch; t++)
			@(posedge CLK_200M);
		if (!in_batch)
			timeout_fail("first load read");
	endtask

	task automatic load_phase(input int n);
		int got;
		int t;
		got = 0;
		for (t = 0; t < 4000 && got < n * lines_per_read; t++) begin
			@(posedge CLK_200M);
			if (eng_load_valid) begin
				check_line("eng_load_data", eng_load_data,
					mem_read(input_base + addr_t'(got)));
				got++;
			end
		end
		if (got < n * lines_per_read)
			timeout_fail("engine load lines");
		check_batch("eng_batch_size", eng_batch_size, batch_t'(n));
		check_bit("eng_reset_n", eng_reset_n, 1'b1);
		eng_load_done <= 1'b1;
		@(posedge CLK_200M);
		eng_load_done <= 1'b0;
	endtask

	task automatic lookup_phase();
		int t;
		foreach (lk_k[j]) begin
			eng_req_valid <= 1'b1;
			eng_addr_k    <= lk_k[j];
			eng_addr_l    <= lk_l[j];
			@(posedge CLK_200M);
			eng_req_valid <= 1'b0;
			for (t = 0; t < 2000 && !eng_rsp_valid; t++)
				@(posedge CLK_200M);
			if (!eng_rsp_valid)
				timeout_fail("lookup response pair");
			check_line("eng_rsp_k", eng_rsp_k, mem_read(src_ptr + addr_t'(lk_k[j][31:4])));
			check_line("eng_rsp_l", eng_rsp_l, mem_read(src_ptr + addr_t'(lk_l[j][31:4])));
		end
		eng_req_done <= 1'b1;
		@(posedge CLK_200M);
		eng_req_done <= 1'b0;
	endtask

	task automatic output_phase();
		int t;
		int w0;
		for (t = 0; t < 2000 && !eng_out_permit; t++)
			@(posedge CLK_200M);
		if (!eng_out_permit)
			timeout_fail("eng_out_permit");
		foreach (res[j]) begin
			w0 = wr_seen;
			eng_out_valid <= 1'b1;
			eng_out_data  <= res[j];
			@(posedge CLK_200M);
			eng_out_valid <= 1'b0;
			for (t = 0; t < 2000 && wr_seen == w0; t++)
				@(posedge CLK_200M);
			if (wr_seen == w0)
				timeout_fail("result write");
		end
		eng_out_finish <= 1'b1;
		@(posedge CLK_200M);
		eng_out_finish <= 1'b0;
		for (t = 0; t < 2000 && exp_wr.size() != 0; t++)
			@(posedge CLK_200M);
		if (exp_wr.size() != 0)
			timeout_fail("completion writes");
	endtask

	initial begin
		int err0;
		void'($urandom(80344));
		reset_n        = 1'b0;
		core_start     = 1'b0;
		rd_almostfull  = 1'b0;
		wr_almostfull  = 1'b0;
		rx_rd_valid    = 1'b0;
		rx_rd_data     = '0;
		hand_ptr       = addr_t'('h100);
		src_ptr        = addr_t'('h10_0000);
		dst_ptr        = addr_t'('h200_0000);
		input_base     = addr_t'('h1000);
		eng_load_done  = 1'b0;
		eng_req_valid  = 1'b0;
		eng_addr_k     = '0;
		eng_addr_l     = '0;
		eng_req_done   = 1'b0;
		eng_out_valid  = 1'b0;
		eng_out_data   = '0;
		eng_out_finish = 1'b0;
		mem[hand_ptr]  = '0;
		repeat (3) @(posedge CLK_200M);
		reset_n <= 1'b1;

		err0 = errors;
		repeat (20) begin
			@(posedge CLK_200M);
			if (tx_rd_valid || tx_wr_valid || eng_load_valid || eng_rsp_valid ||
				eng_out_permit)
				report_error("strobe seen while core_start is low");
			check_bit("eng_reset_n", eng_reset_n, 1'b0);
		end
		report_test(1, "idle after reset", err0);

		// results keep the fence bit clear
		for (int j = 0; j < 3; j++) begin
			lk_k.push_back($urandom & 32'h000f_fff0);
			lk_l.push_back($urandom & 32'h000f_fff0);
			res.push_back({16{$urandom}} >> 1);
		end
		core_start <= 1'b1;

		err0 = errors;
		poll_phase(2, 1'b0);
		load_phase(2);
		report_test(3, "batch load", err0);
		err0 = errors;
		lookup_phase();
		report_test(4, "lookup pairs", err0);
		err0 = errors;
		output_phase();
		report_test(5, "output and completion", err0);

		// second batch must wait for tag1
		err0 = errors;
		poll_phase(1, 1'b1);
		report_test(2, "handshake polling", err0);
		load_phase(1);
		lookup_phase();
		output_phase();

		err0 = errors;
		stall_en = 1'b1;
		poll_phase(2, 1'b0);
		load_phase(2);
		lookup_phase();
		output_phase();
		report_test(6, "random almost-full", err0);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+bench
source/afu_pkg.sv
source/rsp_lanes_if.sv
source/lane_fifo.sv
source/response_steer.sv
source/pair_join.sv
source/job_sequencer.sv
source/afu_core.sv
bench/tb_afu_core.sv

// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module tb_afu_core -o sim

run: build
	./obj_dir/sim | awk '{ print } /\*\* PASS \*\*/ { p = 1 } END { exit !p }'

lint:
	verilator --lint-only --timing --assert -f project.f --top-module tb_afu_core

clean:
	rm -rf obj_dir
